// File: project.f
src/load_pkg.sv
src/dcache_pkg.sv
src/load_ctrl_fsm.sv
src/load_align.sv
src/load_unit.sv
sim/load_unit_asserts.sv
sim/tb_load_unit.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the load unit simulation with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_load_unit -f project.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: sim/load_unit_asserts.sv
// protocol assertions for the load unit cache, translation and issue ports, bound to load_unit
`timescale 1ns/1ps

module load_unit_asserts (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    pop_ld_o,
    input  logic                    valid_o,
    input  logic                    translation_req_o,
    input  logic                    dtlb_hit_i,
    input  logic                    page_offset_matches_i,
    input  dcache_pkg::dcache_req_t dcache_req_o,
    input  dcache_pkg::dcache_rsp_t dcache_rsp_i
);
    // set once any protocol check has failed
    logic proto_fail = 1'b0;

    logic req;
    logic gnt;
    assign req = dcache_req_o.data_req;
    assign gnt = dcache_rsp_i.data_gnt;

    // index phase held stable until granted
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(req && !gnt) |-> (req
            && dcache_req_o.address_index == $past(dcache_req_o.address_index)
            && dcache_req_o.data_be == $past(dcache_req_o.data_be)
            && dcache_req_o.data_size == $past(dcache_req_o.data_size)))
        else begin
            proto_fail = 1'b1;
            $error("index phase changed before grant");
        end

    // tag phase exactly one cycle after a grant
    a_tag: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o.tag_valid == $past(req && gnt))
        else begin
            proto_fail = 1'b1;
            $error("tag_valid not aligned to grant");
        end

    // a miss at grant kills the tag phase and a hit does not
    a_kill: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dcache_req_o.kill_req == $past(req && gnt && !dtlb_hit_i))
        else begin
            proto_fail = 1'b1;
            $error("kill_req does not follow the TLB miss");
        end

    // translation request kept until the load is taken
    a_treq: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(translation_req_o && !pop_ld_o) |-> translation_req_o)
        else begin
            proto_fail = 1'b1;
            $error("translation request dropped early");
        end

    a_offset: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(req && page_offset_matches_i))
        else begin
            proto_fail = 1'b1;
            $error("cache request during store offset match");
        end

    a_reset: assert property (@(posedge clk_i)
        !rst_ni |-> !(pop_ld_o || valid_o || translation_req_o || req
                      || dcache_req_o.tag_valid || dcache_req_o.kill_req))
        else begin
            proto_fail = 1'b1;
            $error("output active during reset");
        end

endmodule

bind load_unit load_unit_asserts u_asserts (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .pop_ld_o              (pop_ld_o),
    .valid_o               (valid_o),
    .translation_req_o     (translation_req_o),
    .dtlb_hit_i            (dtlb_hit_i),
    .page_offset_matches_i (page_offset_matches_i),
    .dcache_req_o          (dcache_req_o),
    .dcache_rsp_i          (dcache_rsp_i)
);

// File: sim/tb_load_unit.sv
// load unit testbench: clock, reset, LFSR stimulus, cache and TLB models, value checks, timeout
`timescale 1ns/1ps

module tb_load_unit;
    import load_pkg::*;
    import dcache_pkg::*;

    localparam int unsigned NUM_LOADS   = 300;
    // worst case per load stays under 20 cycles plus some margin
    localparam int unsigned CYCLE_LIMIT = NUM_LOADS * 20 + 2000;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   valid_i;
    load_req_t              ld_req;
    logic                   pop_ld_o;
    logic                   valid_o;
    logic [TRANS_ID_W-1:0]  trans_id_o;
    logic [XLEN_W-1:0]      result_o;
    logic                   translation_req_o;
    logic [XLEN_W-1:0]      vaddr_o;
    logic [PADDR_W-1:0]     paddr;
    logic                   dtlb_hit;
    logic [INDEX_W-1:0]     page_offset_o;
    logic                   offset_match;
    dcache_rsp_t            drsp;
    dcache_req_t            dreq;

    // model state
    logic [31:0]            lfsr_q;
    logic [INDEX_W-1:0]     idx_q;
    int unsigned            gnt_cnt;
    int unsigned            miss_cnt;
    int unsigned            miss_dur;
    logic                   miss_pend;
    int unsigned            match_cnt;
    logic                   gap_q;
    logic [TRANS_ID_W-1:0]  next_id;
    int unsigned            accepted;
    int unsigned            done_cnt;
    int unsigned            cycle_cnt;

    // expected results in acceptance order
    logic [TRANS_ID_W-1:0]  exp_id_mem [0:7];
    logic [XLEN_W-1:0]      exp_res_mem [0:7];
    logic [2:0]             wr_ptr;
    logic [2:0]             rd_ptr;
    logic [TRANS_ID_W-1:0]  exp_id_head;
    logic [XLEN_W-1:0]      exp_res_head;

    load_unit u_dut (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .valid_i               (valid_i),
        .ld_req_i              (ld_req),
        .pop_ld_o              (pop_ld_o),
        .valid_o               (valid_o),
        .trans_id_o            (trans_id_o),
        .result_o              (result_o),
        .translation_req_o     (translation_req_o),
        .vaddr_o               (vaddr_o),
        .paddr_i               (paddr),
        .dtlb_hit_i            (dtlb_hit),
        .page_offset_o         (page_offset_o),
        .page_offset_matches_i (offset_match),
        .dcache_rsp_i          (drsp),
        .dcache_req_o          (dreq)
    );

    // ------------------------------
    // helpers
    // ------------------------------
    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // memory content where every address bit reaches the data
    function automatic logic [63:0] dword_pattern(logic [52:0] a);
        return {a[31:0] ^ 32'hc3a5_96e1, a[52:21] ^ {a[20:0], 11'h5b3}};
    endfunction

    // reference extension shifts, cuts to width, then extends
    function automatic logic [63:0] expected_value(ld_op_e op, logic [2:0] off, logic [63:0] d);
        logic [63:0] sh;
        sh = d >> (off * 8);
        case (op)
            LW:      return {{32{sh[31]}}, sh[31:0]};
            LWU:     return {32'h0, sh[31:0]};
            LH:      return {{48{sh[15]}}, sh[15:0]};
            LHU:     return {48'h0, sh[15:0]};
            LB:      return {{56{sh[7]}}, sh[7:0]};
            LBU:     return {56'h0, sh[7:0]};
            default: return sh;
        endcase
    endfunction

    // size code and byte enables of the index phase
    function automatic logic [9:0] size_and_be(ld_op_e op, logic [2:0] off);
        logic [1:0]  sz;
        logic [15:0] mask;
        case (op)
            LW, LWU: sz = 2'd2;
            LH, LHU: sz = 2'd1;
            LB, LBU: sz = 2'd0;
            default: sz = 2'd3;
        endcase
        // one enable per byte of the item, moved up to its offset
        mask = ((16'd1 << (1 << sz)) - 16'd1) << off;
        return {sz, mask[7:0]};
    endfunction

    // fixed page translation that keeps the page offset
    assign paddr = {ld_req.vaddr[PADDR_W-1:INDEX_W] ^ 44'h5a5_3c1e_7d2,
                    ld_req.vaddr[INDEX_W-1:0]};

    task automatic fail_run(string what);
        $display("Error: time %0t: %s", $time, what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // new request with an aligned offset for its operation
    task automatic present_next();
        ld_op_e       op;
        logic [2:0]   off;
        logic [29:0]  addr;
        logic [31:0]  r;
        r  = rand_bits(3);
        op = ld_op_e'(r[2:0] % 3'd7);
        case (op)
            LD: off = 3'd0;
            LW, LWU: begin
                r   = rand_bits(1);
                off = {r[0], 2'b00};
            end
            LH, LHU: begin
                r   = rand_bits(2);
                off = {r[1:0], 1'b0};
            end
            default: begin
                r   = rand_bits(3);
                off = r[2:0];
            end
        endcase
        r    = rand_bits(30);
        addr = r[29:0];
        ld_req.trans_id <= next_id;
        ld_req.vaddr    <= {31'h0, addr, off};
        ld_req.op       <= op;
        valid_i         <= 1'b1;
        next_id         <= next_id + 1'b1;
    endtask

    // ------------------------------
    // clock and reset
    // ------------------------------
    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        rst_ni = 1'b0;
        valid_i = 1'b0;
        ld_req = '0;
        dtlb_hit = 1'b0;
        offset_match = 1'b0;
        drsp = '0;
        lfsr_q = 32'h526caa78;
        idx_q = '0;
        gnt_cnt = 0;
        miss_cnt = 0;
        miss_dur = 1;
        miss_pend = 1'b0;
        match_cnt = 0;
        gap_q = 1'b1;
        next_id = '0;
        accepted = 0;
        done_cnt = 0;
        cycle_cnt = 0;
        wr_ptr = '0;
        rd_ptr = '0;
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        while (done_cnt < NUM_LOADS) @(posedge clk_i);
        repeat (2) @(posedge clk_i);
        if (u_dut.u_asserts.proto_fail) begin
            fail_run("a protocol assertion on the load unit ports failed");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

    always @(posedge clk_i) begin : p_timeout
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            fail_run("timeout, loads did not complete in time");
        end else if (u_dut.u_asserts.proto_fail) begin
            fail_run("a protocol assertion on the load unit ports failed");
        end
    end

    // ------------------------------
    // cache, TLB and issue models
    // ------------------------------
    always @(posedge clk_i) begin : p_models
        if (rst_ni) begin
            // index phase is remembered for the tag cycle
            if (dreq.data_req && drsp.data_gnt) begin
                idx_q <= dreq.address_index;
            end
            drsp.data_rvalid <= dreq.tag_valid && !dreq.kill_req;
            drsp.data_rdata  <= dword_pattern({dreq.address_tag, idx_q[INDEX_W-1:3]});

            if (valid_o) begin
                rd_ptr   <= rd_ptr + 1'b1;
                done_cnt <= done_cnt + 1;
            end

            if (pop_ld_o) begin
                exp_id_mem[wr_ptr]  <= ld_req.trans_id;
                exp_res_mem[wr_ptr] <= expected_value(ld_req.op, ld_req.vaddr[2:0],
                                                      dword_pattern(paddr[PADDR_W-1:3]));
                wr_ptr   <= wr_ptr + 1'b1;
                accepted <= accepted + 1;
                // timing of the next load
                gnt_cnt   = rand_bits(2);
                miss_pend = (rand_bits(2) == 2'd0);
                miss_dur  = 1 + rand_bits(2) % 3;
                miss_cnt  = 0;
                match_cnt = (rand_bits(2) == 2'd0) ? 1 + rand_bits(2) : 0;
                if (accepted + 1 >= NUM_LOADS) begin
                    valid_i <= 1'b0;
                    gap_q   <= 1'b0;
                end else if (rand_bits(3) == 3'd0) begin
                    valid_i <= 1'b0;
                    gap_q   <= 1'b1;
                end else begin
                    present_next();
                end
            end else begin
                if (gap_q) begin
                    gap_q <= 1'b0;
                    present_next();
                end
                if (dreq.data_req && !drsp.data_gnt && gnt_cnt > 0) begin
                    gnt_cnt--;
                end
                // a miss at grant starts the walk
                if (dreq.data_req && drsp.data_gnt && !dtlb_hit) begin
                    miss_pend = 1'b0;
                    miss_cnt  = miss_dur;
                end else if (miss_cnt > 0) begin
                    miss_cnt--;
                end
                if (valid_i && match_cnt > 0) begin
                    match_cnt--;
                end
            end
            drsp.data_gnt <= (gnt_cnt == 0);
            dtlb_hit      <= !miss_pend && (miss_cnt == 0);
            offset_match  <= (match_cnt > 0);
        end
    end

    // ------------------------------
    // value checks
    // ------------------------------
    assign exp_id_head  = exp_id_mem[rd_ptr];
    assign exp_res_head = exp_res_mem[rd_ptr];

    a_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o |-> (trans_id_o == exp_id_head && result_o == exp_res_head))
        else fail_run("result or transaction id differs from the expected load value");

    a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(pop_ld_o, 2) |-> valid_o)
        else fail_run("accepted load gave no result two cycles later");

    a_no_extra: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o |-> $past(pop_ld_o, 2))
        else fail_run("result appeared without an accepted load two cycles before");

    // TLB and store buffer see the address of the presented request
    a_addr_out: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i |-> (vaddr_o == ld_req.vaddr
                     && page_offset_o == ld_req.vaddr[INDEX_W-1:0]))
        else fail_run("vaddr or page offset output differs from the presented request");

    a_index_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dreq.data_req |-> ({dreq.data_size, dreq.data_be}
                               == size_and_be(ld_req.op, ld_req.vaddr[2:0])
                           && dreq.address_index == ld_req.vaddr[INDEX_W-1:0]))
        else fail_run("index phase size, byte enables or index differ from the request");

endmodule

// File: src/dcache_pkg.sv
// data cache request and response port structs, address split and data widths
package dcache_pkg;

    // ------------------------------
    // address split
    // ------------------------------
    // physical address width of the core
    localparam int unsigned PADDR_W = 56;
    // page offset, also used as cache index
    localparam int unsigned INDEX_W = 12;
    // tag sent one cycle after the index
    localparam int unsigned TAG_W = PADDR_W - INDEX_W;

    // ------------------------------
    // data path
    // ------------------------------
    // read data width of the cache port
    localparam int unsigned DATA_W = 64;
    // one enable per byte of the read data
    localparam int unsigned BE_W = DATA_W / 8;

    // ------------------------------
    // port structs
    // ------------------------------
    // load unit to cache
    // index phase: data_req, address_index, data_be, data_size
    // tag phase:   address_tag, tag_valid, kill_req
    typedef struct packed {
        logic [INDEX_W-1:0] address_index;
        logic [TAG_W-1:0]   address_tag;
        logic               data_req;
        logic [BE_W-1:0]    data_be;
        logic [1:0]         data_size;
        logic               tag_valid;
        logic               kill_req;
    } dcache_req_t;

    // cache to load unit
    // data_gnt closes the index phase, data_rvalid comes one cycle after the tag
    typedef struct packed {
        logic              data_gnt;
        logic              data_rvalid;
        logic [DATA_W-1:0] data_rdata;
    } dcache_rsp_t;

endpackage

// File: src/load_align.sv
// load result path: two-stage metadata pipeline, fast sign-bit select, result mux
`timescale 1ns/1ps

module load_align (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // accepted load from the FSM
    input  logic                              pop_i,
    input  load_pkg::load_meta_t              meta_i,
    // tag phase seen on the cache port
    input  logic                              tag_valid_i,
    input  logic                              kill_i,
    // cache response
    input  dcache_pkg::dcache_rsp_t           dcache_rsp_i,
    // result to the core
    output logic                              valid_o,
    output logic [load_pkg::TRANS_ID_W-1:0]   trans_id_o,
    output logic [load_pkg::XLEN_W-1:0]       result_o
);
    import load_pkg::*;

    // metadata plus the sign select prepared ahead of the data
    typedef struct packed {
        load_meta_t          meta;
        logic                sign_ext;
        logic [OFFSET_W-1:0] sign_idx;
    } stage_t;

    stage_t              stage_d, stage1_q, stage2_q;
    logic                stage2_valid_q;
    logic [XLEN_W-1:0]   shifted;
    logic [7:0]          sign_bits;
    logic                sign_bit;

    // ------------------------------
    // precompute on pop
    // ------------------------------
    // sign byte is the top byte of the loaded item
    always_comb begin : p_prep
        stage_d.meta     = meta_i;
        stage_d.sign_ext = meta_i.op inside {LW, LH, LB};
        unique case (meta_i.op)
            LW, LWU: stage_d.sign_idx = meta_i.offset + OFFSET_W'(3);
            LH, LHU: stage_d.sign_idx = meta_i.offset + OFFSET_W'(1);
            default: stage_d.sign_idx = meta_i.offset;
        endcase
    end

    // ------------------------------
    // metadata pipeline
    // ------------------------------
    // stage 1 holds the load between grant and tag
    // stage 2 holds it between tag and rvalid
    always_ff @(posedge clk_i) begin : p_stages
        if (pop_i) begin
            stage1_q <= stage_d;
        end
        if (tag_valid_i && !kill_i) begin
            stage2_q <= stage1_q;
        end
    end

    // killed tag phase gives no response, so stage 2 stays empty
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            stage2_valid_q <= 1'b0;
        end else begin
            stage2_valid_q <= tag_valid_i & ~kill_i;
        end
    end

    // ------------------------------
    // realign and extend
    // ------------------------------
    assign shifted = dcache_rsp_i.data_rdata >> {stage2_q.meta.offset, 3'b000};

    // msb of every byte, picked in parallel to the shifter
    always_comb begin : p_sign_bits
        for (int i = 0; i < 8; i++) begin
            sign_bits[i] = dcache_rsp_i.data_rdata[8*i+7];
        end
    end

    // unsigned loads pull the fill to zero
    assign sign_bit = stage2_q.sign_ext & sign_bits[stage2_q.sign_idx];

    always_comb begin : p_result
        unique case (stage2_q.meta.op)
            LW, LWU: result_o = {{32{sign_bit}}, shifted[31:0]};
            LH, LHU: result_o = {{48{sign_bit}}, shifted[15:0]};
            LB, LBU: result_o = {{56{sign_bit}}, shifted[7:0]};
            default: result_o = shifted;
        endcase
    end

    assign valid_o    = dcache_rsp_i.data_rvalid & stage2_valid_q;
    assign trans_id_o = stage2_q.meta.trans_id;

endmodule

// File: src/load_ctrl_fsm.sv
// load request FSM: translation, store-offset stall, cache grant, tag phase and abort
`timescale 1ns/1ps

module load_ctrl_fsm (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // issue side
    input  logic                      valid_i,
    input  load_pkg::load_req_t       ld_req_i,
    output logic                      pop_ld_o,
    // accepted load towards the aligner
    output load_pkg::load_meta_t      meta_o,
    // translation
    output logic                      translation_req_o,
    input  logic [dcache_pkg::PADDR_W-1:0] paddr_i,
    input  logic                      dtlb_hit_i,
    // store buffer offset check
    input  logic                      page_offset_matches_i,
    // data cache
    input  logic                      dcache_gnt_i,
    output dcache_pkg::dcache_req_t   dcache_req_o
);
    import load_pkg::*;
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT,
        WAIT_TRANSLATION
    } state_e;

    state_e            state_d, state_q;
    logic [TAG_W-1:0]  tag_q;
    logic [BE_W-1:0]   be;
    logic [1:0]        size;
    logic              gnt_taken;

    // ------------------------------
    // size and byte enables
    // ------------------------------
    // derived from the operation and the low vaddr bits
    always_comb begin : p_be
        unique case (ld_req_i.op)
            LW, LWU: begin
                size = 2'b10;
                be   = BE_W'(8'h0f) << ld_req_i.vaddr[OFFSET_W-1:0];
            end
            LH, LHU: begin
                size = 2'b01;
                be   = BE_W'(8'h03) << ld_req_i.vaddr[OFFSET_W-1:0];
            end
            LB, LBU: begin
                size = 2'b00;
                be   = BE_W'(8'h01) << ld_req_i.vaddr[OFFSET_W-1:0];
            end
            // full doubleword
            default: begin
                size = 2'b11;
                be   = '1;
            end
        endcase
    end

    // metadata of the request currently presented, captured downstream on pop
    assign meta_o = '{
        trans_id: ld_req_i.trans_id,
        offset:   ld_req_i.vaddr[OFFSET_W-1:0],
        op:       ld_req_i.op
    };

    // ------------------------------
    // request control
    // ------------------------------
    always_comb begin : p_ctrl
        state_d           = state_q;
        translation_req_o = 1'b0;
        // index comes straight from the held request
        dcache_req_o.address_index = ld_req_i.vaddr[INDEX_W-1:0];
        // tag was captured in the grant cycle
        dcache_req_o.address_tag   = tag_q;
        dcache_req_o.data_req      = 1'b0;
        dcache_req_o.data_be       = be;
        dcache_req_o.data_size     = size;
        dcache_req_o.tag_valid     = 1'b0;
        dcache_req_o.kill_req      = 1'b0;

        unique case (state_q)
            // send tag finishes the previous load and may start the next one
            IDLE, SEND_TAG: begin
                dcache_req_o.tag_valid = (state_q == SEND_TAG);
                state_d = IDLE;
                if (valid_i) begin
                    // start translating right away, the offset check runs in parallel
                    translation_req_o = 1'b1;
                    if (page_offset_matches_i) begin
                        // a store to the same offset is pending, hold off
                        state_d = WAIT_PAGE_OFFSET;
                    end else begin
                        dcache_req_o.data_req = 1'b1;
                        if (!dcache_gnt_i) begin
                            state_d = WAIT_GNT;
                        end else if (dtlb_hit_i) begin
                            state_d = SEND_TAG;
                        end else begin
                            state_d = ABORT;
                        end
                    end
                end
            end

            // stalled behind a store with the same page offset
            WAIT_PAGE_OFFSET: begin
                translation_req_o = 1'b1;
                if (!page_offset_matches_i) begin
                    state_d = WAIT_GNT;
                end
            end

            // index phase held until the cache grants
            WAIT_GNT: begin
                translation_req_o     = 1'b1;
                dcache_req_o.data_req = 1'b1;
                if (dcache_gnt_i) begin
                    state_d = dtlb_hit_i ? SEND_TAG : ABORT;
                end
            end

            // granted without a translation, kill the tag phase
            ABORT: begin
                translation_req_o      = 1'b1;
                dcache_req_o.tag_valid = 1'b1;
                dcache_req_o.kill_req  = 1'b1;
                state_d = WAIT_TRANSLATION;
            end

            // let the page walk finish, then ask again
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // grant of the index phase in this cycle
    assign gnt_taken = dcache_req_o.data_req & dcache_gnt_i;
    // the load is accepted only when the translation is there as well
    assign pop_ld_o  = gnt_taken & dtlb_hit_i;

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // physical tag for the cycle after the grant
    always_ff @(posedge clk_i) begin : p_tag
        if (gnt_taken) begin
            tag_q <= paddr_i[PADDR_W-1:INDEX_W];
        end
    end

endmodule

// File: src/load_pkg.sv
// load operation encoding, load request and metadata structs, data and id widths
package load_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    // integer data and virtual address width
    localparam int unsigned XLEN_W = 64;
    // transaction id handed back with the result
    localparam int unsigned TRANS_ID_W = 3;
    // byte offset inside one doubleword
    localparam int unsigned OFFSET_W = 3;

    // ------------------------------
    // load operations
    // ------------------------------
    // u suffix means zero extension, the rest sign extend
    typedef enum logic [2:0] {
        LD  = 3'd0,
        LW  = 3'd1,
        LWU = 3'd2,
        LH  = 3'd3,
        LHU = 3'd4,
        LB  = 3'd5,
        LBU = 3'd6
    } ld_op_e;

    // ------------------------------
    // structs
    // ------------------------------
    // request as presented by the issue side
    typedef struct packed {
        logic [TRANS_ID_W-1:0] trans_id;
        logic [XLEN_W-1:0]     vaddr;
        ld_op_e                op;
    } load_req_t;

    // what the result path needs to remember per accepted load
    // vaddr bits above the doubleword are not needed any more
    typedef struct packed {
        logic [TRANS_ID_W-1:0] trans_id;
        logic [OFFSET_W-1:0]   offset;
        ld_op_e                op;
    } load_meta_t;

endpackage

// File: src/load_unit.sv
// load unit top: request FSM and result aligner, address feed-through
`timescale 1ns/1ps

module load_unit (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // issue side
    input  logic                              valid_i,
    input  load_pkg::load_req_t               ld_req_i,
    output logic                              pop_ld_o,
    // result
    output logic                              valid_o,
    output logic [load_pkg::TRANS_ID_W-1:0]   trans_id_o,
    output logic [load_pkg::XLEN_W-1:0]       result_o,
    // translation
    output logic                              translation_req_o,
    output logic [load_pkg::XLEN_W-1:0]       vaddr_o,
    input  logic [dcache_pkg::PADDR_W-1:0]    paddr_i,
    input  logic                              dtlb_hit_i,
    // store offset check
    output logic [dcache_pkg::INDEX_W-1:0]    page_offset_o,
    input  logic                              page_offset_matches_i,
    // data cache port
    input  dcache_pkg::dcache_rsp_t           dcache_rsp_i,
    output dcache_pkg::dcache_req_t           dcache_req_o
);
    import load_pkg::*;
    import dcache_pkg::*;

    load_meta_t meta;

    // vaddr goes to the TLB, its low bits to the store buffer
    assign vaddr_o       = ld_req_i.vaddr;
    assign page_offset_o = ld_req_i.vaddr[INDEX_W-1:0];

    // ------------------------------
    // request side
    // ------------------------------
    load_ctrl_fsm u_ctrl (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .valid_i               (valid_i),
        .ld_req_i              (ld_req_i),
        .pop_ld_o              (pop_ld_o),
        .meta_o                (meta),
        .translation_req_o     (translation_req_o),
        .paddr_i               (paddr_i),
        .dtlb_hit_i            (dtlb_hit_i),
        .page_offset_matches_i (page_offset_matches_i),
        .dcache_gnt_i          (dcache_rsp_i.data_gnt),
        .dcache_req_o          (dcache_req_o)
    );

    // ------------------------------
    // result side
    // ------------------------------
    // follows the tag phase the FSM drives on the cache port
    load_align u_align (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .pop_i        (pop_ld_o),
        .meta_i       (meta),
        .tag_valid_i  (dcache_req_o.tag_valid),
        .kill_i       (dcache_req_o.kill_req),
        .dcache_rsp_i (dcache_rsp_i),
        .valid_o      (valid_o),
        .trans_id_o   (trans_id_o),
        .result_o     (result_o)
    );

endmodule
